/* vlog.f */
+incdir+design
design/serv_pkg.sv
design/serv_decode.sv
design/serv_regfile.sv
design/serv_execute.sv
design/serv_result.sv
design/serv_core.sv
tests/serv_chk.sv
tests/serv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the serv_tb model with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module serv_tb -f vlog.f -o serv_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/serv_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
fi
exit $status

/* tests/serv_input.txt */
// Columns: instruction word, expected rd (00 when nothing is written), expected rd value
// All hex, one instruction per line in fetch order
00500093 01 00000005
ffd00113 02 fffffffd
fff0c193 03 fffffffa
7f00e213 04 000007f5
ff017293 05 fffffff0
00208333 06 00000002
402083b3 07 00000008
0041f433 08 000007f0
0012e4b3 09 fffffff5
0034c533 0a 0000000f
001125b3 0b 00000001
00113633 0c 00000000
fff0b693 0d 00000001
80012713 0e 00000000
00708013 00 00000000
00208463 00 00000000
00309313 00 00000000
022083b3 00 00000000
007307b3 0f 0000000a
00046833 10 000007f0
00103893 11 00000001

/* tests/serv_tb.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_tb
   import serv_pkg::*;
();

   localparam int NUM_INSTR      = 21;
   localparam int FETCH_TIMEOUT  = 8;
   localparam int RETIRE_TIMEOUT = `SERV_RETIRE_LATENCY + 16;

   logic                  clk;
   logic                  reset;
   logic                  ibus_cyc;
   logic [`SERV_XLEN-1:0] ibus_adr;
   logic                  ibus_ack;
   instr_u                ibus_rdt;
   retire_s               retire;
   logic                  retire_valid;

   // Three words per line: instruction, expected rd, expected value
   logic [31:0]           stim [0:3*NUM_INSTR-1];
   integer                seed;
   logic [`SERV_XLEN-1:0] exp_pc;

   serv_core dut0 (
      .clk            (clk),
      .i_reset        (reset),
      .o_ibus_cyc     (ibus_cyc),
      .o_ibus_adr     (ibus_adr),
      .i_ibus_ack     (ibus_ack),
      .i_ibus_rdt     (ibus_rdt),
      .o_retire       (retire),
      .o_retire_valid (retire_valid)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_addr(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      if (act !== exp) begin
         abort_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic compare_retire(input retire_s exp, input retire_s act);
      if (act.rd !== exp.rd) begin
         abort_run($sformatf("Fail o_retire.rd: expected %h, got %h", exp.rd, act.rd));
      end
      if (act.wen !== exp.wen) begin
         abort_run($sformatf("Fail o_retire.wen: expected %h, got %h", exp.wen, act.wen));
      end
      // Data only matters when a write happens
      if (exp.wen && (act.data !== exp.data)) begin
         abort_run($sformatf("Fail o_retire.data: expected %h, got %h",
                             exp.data, act.data));
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      if (act != exp) begin
         abort_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
      end
   endtask

   task automatic wait_for_fetch();
      int cycles;
      cycles = 0;
      while (!ibus_cyc) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > FETCH_TIMEOUT) begin
            abort_run("Timeout: the core did not start an instruction fetch");
         end
      end
   endtask

   // Answer the pending fetch after 0 to 3 idle cycles
   task automatic serve_fetch(input instr_u word);
      logic [31:0] rnd;
      int          gap;
      rnd = $random(seed);
      gap = int'(rnd[1:0]);
      for (int k = 0; k < gap; k++) begin
         @(posedge clk);
         #1;
         if (!ibus_cyc) begin
            abort_run("The core dropped its fetch before the acknowledge");
         end
         compare_addr("o_ibus_adr", exp_pc, ibus_adr);
      end
      ibus_ack = 1'b1;
      ibus_rdt = word;
      @(posedge clk);
      #1;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
   endtask

   // Counts edges from the acknowledge edge
   task automatic wait_for_retire(output int edges);
      edges = 0;
      while (!retire_valid) begin
         @(posedge clk);
         #1;
         edges++;
         if (edges > RETIRE_TIMEOUT) begin
            abort_run("Timeout: the core did not retire the fetched instruction");
         end
      end
   endtask

   initial begin
      instr_u  word;
      retire_s expected;
      int      edges;
      seed     = 32'h9948_9ce7;
      reset    = 1'b1;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      exp_pc   = `SERV_RESET_PC;
      $readmemh("tests/serv_input.txt", stim);
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < NUM_INSTR; i++) begin
         word = stim[3*i];
         wait_for_fetch();
         compare_addr("o_ibus_adr", exp_pc, ibus_adr);
         serve_fetch(word);
         if (ibus_cyc) begin
            abort_run("The fetch cycle stayed open after the acknowledge");
         end
         wait_for_retire(edges);
         compare_count("retire latency", `SERV_RETIRE_LATENCY, edges);
         // Expected rd 0 marks a retirement with no write
         expected.wen  = (stim[3*i+1][4:0] != 5'd0);
         expected.rd   = expected.wen ? stim[3*i+1][4:0] : word.i.rd;
         expected.data = stim[3*i+2];
         compare_retire(expected, retire);
         exp_pc = exp_pc + 32'd4;
      end
      if (dut0.chk0.fail_count != 0) begin
         abort_run("A bus or retire protocol assertion failed during the run");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

/* tests/serv_chk.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_chk (
   input logic                  clk,
   input logic                  i_reset,
   input logic                  i_ibus_cyc,
   input logic                  i_ibus_ack,
   input logic [`SERV_XLEN-1:0] i_ibus_adr,
   input logic                  i_retire_valid
);

   int unsigned fail_count = 0;

   // Address holds until the fetch is acknowledged
   adr_hold: assert property (@(posedge clk) disable iff (i_reset)
      (i_ibus_cyc && !i_ibus_ack) |=> $stable(i_ibus_adr))
      else begin
         $error("instruction address changed while a fetch was pending");
         fail_count++;
      end

   retire_single: assert property (@(posedge clk) disable iff (i_reset)
      i_retire_valid |=> !i_retire_valid)
      else begin
         $error("retire strobe held high for two cycles");
         fail_count++;
      end

   // Core is either fetching or retiring, never both
   fetch_or_retire: assert property (@(posedge clk) disable iff (i_reset)
      !(i_ibus_cyc && i_retire_valid))
      else begin
         $error("fetch cycle and retire strobe high together");
         fail_count++;
      end

endmodule

bind serv_core serv_chk chk0 (
   .clk            (clk),
   .i_reset        (i_reset),
   .i_ibus_cyc     (o_ibus_cyc),
   .i_ibus_ack     (i_ibus_ack),
   .i_ibus_adr     (o_ibus_adr),
   .i_retire_valid (o_retire_valid)
);

/* design/serv_core.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_core
   import serv_pkg::*;
(
   input  logic                  clk,
   input  logic                  i_reset,
   output logic                  o_ibus_cyc,
   output logic [`SERV_XLEN-1:0] o_ibus_adr,
   input  logic                  i_ibus_ack,
   input  instr_u                i_ibus_rdt,
   output retire_s               o_retire,
   output logic                  o_retire_valid
);

   decoded_s              dec;
   logic                  start;
   logic [`SERV_XLEN-1:0] rs1;
   logic [`SERV_XLEN-1:0] rs2;
   logic                  rd_bit;
   logic                  bit_valid;
   logic                  last;
   logic                  cmp;

   serv_decode decode (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_ibus_ack     (i_ibus_ack),
      .i_ibus_rdt     (i_ibus_rdt),
      .i_retire_valid (o_retire_valid),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_ibus_adr     (o_ibus_adr),
      .o_dec          (dec),
      .o_start        (start)
   );

   serv_regfile regfile (
      .clk            (clk),
      .i_rs1_addr     (dec.rs1),
      .i_rs2_addr     (dec.rs2),
      .o_rs1          (rs1),
      .o_rs2          (rs2),
      .i_retire       (o_retire),
      .i_retire_valid (o_retire_valid)
   );

   serv_execute execute (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_start     (start),
      .i_dec       (dec),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .o_rd_bit    (rd_bit),
      .o_bit_valid (bit_valid),
      .o_last      (last),
      .o_cmp       (cmp)
   );

   serv_result result (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_dec          (dec),
      .i_rd_bit       (rd_bit),
      .i_bit_valid    (bit_valid),
      .i_last         (last),
      .i_cmp          (cmp),
      .o_retire       (o_retire),
      .o_retire_valid (o_retire_valid)
   );

endmodule

/* design/serv_result.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_result
   import serv_pkg::*;
(
   input  logic     clk,
   input  logic     i_reset,
   input  decoded_s i_dec,
   input  logic     i_rd_bit,
   input  logic     i_bit_valid,
   input  logic     i_last,
   input  logic     i_cmp,
   output retire_s  o_retire,
   output logic     o_retire_valid
);

   logic [`SERV_XLEN-1:0] res;
   logic                  is_cmp;

   assign is_cmp = (i_dec.op == ALU_SLT) || (i_dec.op == ALU_SLTU);

   // Bits arrive LSB first and enter at the top
   always_ff @(posedge clk) begin
      if (i_bit_valid) begin
         if (i_last && is_cmp) begin
            res <= {{(`SERV_XLEN-1){1'b0}}, i_cmp};
         end else begin
            res <= {i_rd_bit, res[`SERV_XLEN-1:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_retire_valid <= 1'b0;
      end else begin
         o_retire_valid <= i_bit_valid && i_last;
      end
   end

   assign o_retire = '{rd: i_dec.rd, wen: i_dec.wen, data: res};

endmodule

/* design/serv_execute.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_execute
   import serv_pkg::*;
(
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_start,
   input  decoded_s              i_dec,
   input  logic [`SERV_XLEN-1:0] i_rs1,
   input  logic [`SERV_XLEN-1:0] i_rs2,
   output logic                  o_rd_bit,
   output logic                  o_bit_valid,
   output logic                  o_last,
   output logic                  o_cmp
);

   logic [`SERV_XLEN-1:0]  op_a;
   logic [`SERV_XLEN-1:0]  op_b;
   logic [`SERV_CNT_W-1:0] cnt;
   logic                   active;
   alu_op_e                op;
   logic                   carry;
   logic                   carry_next;
   logic                   a;
   logic                   b;
   logic                   sum;
   logic                   lt_signed;
   logic                   lt_unsigned;

   // SUB and both compares run through the subtract path
   function automatic logic subtracts(input alu_op_e f_op);
      return (f_op == ALU_SUB) || (f_op == ALU_SLT) || (f_op == ALU_SLTU);
   endfunction

   always_ff @(posedge clk) begin
      if (i_reset) begin
         active <= 1'b0;
         cnt    <= '0;
      end else if (i_start) begin
         active <= 1'b1;
         cnt    <= '0;
      end else if (active) begin
         cnt <= cnt + 1'b1;
         if (&cnt) begin
            active <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_start) begin
         op_a  <= i_rs1;
         op_b  <= i_dec.use_imm ? {{(`SERV_XLEN-12){i_dec.imm[11]}}, i_dec.imm} : i_rs2;
         op    <= i_dec.op;
         carry <= subtracts(i_dec.op);
      end else if (active) begin
         op_a  <= op_a >> 1;
         op_b  <= op_b >> 1;
         carry <= carry_next;
      end
   end

   assign a          = op_a[0];
   assign b          = op_b[0] ^ subtracts(op);
   assign sum        = a ^ b ^ carry;
   assign carry_next = (a & b) | (carry & (a ^ b));

   always_comb begin
      case (op)
         ALU_AND: o_rd_bit = a & op_b[0];
         ALU_OR:  o_rd_bit = a | op_b[0];
         ALU_XOR: o_rd_bit = a ^ op_b[0];
         default: o_rd_bit = sum;
      endcase
   end

   // On the last bit a and op_b[0] are the sign bits
   assign lt_signed   = (a != op_b[0]) ? a : sum;
   // No carry out means a borrow
   assign lt_unsigned = !carry_next;

   assign o_cmp       = (op == ALU_SLT) ? lt_signed : lt_unsigned;
   assign o_bit_valid = active;
   assign o_last      = active && (&cnt);

endmodule

/* design/serv_regfile.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_regfile
   import serv_pkg::*;
(
   input  logic                  clk,
   input  logic [4:0]            i_rs1_addr,
   input  logic [4:0]            i_rs2_addr,
   output logic [`SERV_XLEN-1:0] o_rs1,
   output logic [`SERV_XLEN-1:0] o_rs2,
   input  retire_s               i_retire,
   input  logic                  i_retire_valid
);

   // x1 to x31 only
   logic [`SERV_XLEN-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (i_retire_valid && i_retire.wen && (i_retire.rd != 5'd0)) begin
         regs[i_retire.rd] <= i_retire.data;
      end
   end

   // x0 reads as zero
   assign o_rs1 = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

/* design/serv_decode.sv */
`timescale 1ns/1ns
`include "serv_settings.svh"

module serv_decode
   import serv_pkg::*;
(
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_ibus_ack,
   input  instr_u                i_ibus_rdt,
   input  logic                  i_retire_valid,
   output logic                  o_ibus_cyc,
   output logic [`SERV_XLEN-1:0] o_ibus_adr,
   output decoded_s              o_dec,
   output logic                  o_start
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_FETCH = 2'd1;
   localparam logic [1:0] ST_BUSY  = 2'd2;

   logic [1:0]            state;
   logic [`SERV_XLEN-1:0] pc;
   logic                  fetched;
   instr_u                ir;
   decoded_s              dec_next;
   logic                  is_op;
   logic                  is_opimm;
   logic                  f3_ok;
   logic                  f7_ok;
   logic                  supported;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state   <= ST_IDLE;
         pc      <= `SERV_RESET_PC;
         fetched <= 1'b0;
         o_start <= 1'b0;
      end else begin
         fetched <= 1'b0;
         o_start <= fetched;
         case (state)
            ST_IDLE: begin
               state <= ST_FETCH;
            end
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state   <= ST_BUSY;
                  fetched <= 1'b1;
               end
            end
            ST_BUSY: begin
               if (i_retire_valid) begin
                  state <= ST_FETCH;
                  pc    <= pc + 32'd4;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (o_ibus_cyc && i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
      // Decoded fields register one edge after the word
      if (fetched) begin
         o_dec <= dec_next;
      end
   end

   always_comb begin
      is_op    = (ir.r.opcode == `SERV_OPCODE_OP);
      is_opimm = (ir.i.opcode == `SERV_OPCODE_OPIMM);
      // Only SUB may set funct7 bit 5
      f7_ok    = !is_op || (ir.r.funct7 == 7'b0000000) ||
                 ((ir.r.funct7 == 7'b0100000) && (ir.r.funct3 == 3'b000));
      f3_ok    = 1'b1;
      dec_next.op = ALU_ADD;
      case (ir.r.funct3)
         3'b000:  dec_next.op = (is_op && ir.r.funct7[5]) ? ALU_SUB : ALU_ADD;
         3'b010:  dec_next.op = ALU_SLT;
         3'b011:  dec_next.op = ALU_SLTU;
         3'b100:  dec_next.op = ALU_XOR;
         3'b110:  dec_next.op = ALU_OR;
         3'b111:  dec_next.op = ALU_AND;
         default: f3_ok = 1'b0;
      endcase
      supported = (is_op || is_opimm) && f3_ok && f7_ok;
      // Anything else retires as a plain add with no write
      if (!supported) begin
         dec_next.op = ALU_ADD;
      end
      dec_next.rs1     = ir.r.rs1;
      dec_next.rs2     = ir.r.rs2;
      dec_next.rd      = ir.r.rd;
      dec_next.use_imm = is_opimm;
      dec_next.wen     = supported && (ir.r.rd != 5'd0);
      dec_next.imm     = ir.i.imm12;
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_ibus_adr = pc;

endmodule

/* design/serv_pkg.sv */
`include "serv_settings.svh"

package serv_pkg;

   // Register-register layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instr_r_s;

   // Register-immediate layout
   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } instr_i_s;

   typedef union packed {
      instr_r_s r;
      instr_i_s i;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   typedef struct packed {
      alu_op_e     op;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
      logic        use_imm;
      logic        wen;
      logic [11:0] imm;
   } decoded_s;

   typedef struct packed {
      logic [4:0]            rd;
      logic                  wen;
      logic [`SERV_XLEN-1:0] data;
   } retire_s;

endpackage

/* design/serv_settings.svh */
`ifndef SERV_SETTINGS_SVH
`define SERV_SETTINGS_SVH

// Data and instruction width
`define SERV_XLEN 32
`define SERV_CNT_W 5

`define SERV_RESET_PC 32'h0000_0000

// Major opcodes handled by the datapath
`define SERV_OPCODE_OP 7'b0110011
`define SERV_OPCODE_OPIMM 7'b0010011

// Rising edges from the fetch acknowledge to the retire strobe
`define SERV_RETIRE_LATENCY 34

`endif
